/* src/icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 128;
    localparam int NSET     = 256;
    localparam int NWAY     = 2;
    localparam int INDEX_W  = $clog2(NSET);
    localparam int OFFSET_W = 4;
    // Whatever is left above index and offset
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    ////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [LINE_W-1:0]        line_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [$clog2(NWAY)-1:0]  way_t;

    // Refill controller, port 1 checked first
    typedef enum logic [2:0] {
        IDLE,
        REQ_1,
        WAIT_1,
        REQ_2,
        WAIT_2
    } refill_state_e;

endpackage

/* src/icache_fill_if.sv */
`timescale 1ns/1ns

interface icache_fill_if
    import icache_pkg::*;
();

    // Lookup side
    logic [1:0] miss;
    addr_t      addr_1;
    addr_t      addr_2;

    // Refill side
    logic       fill_valid;
    logic       fill_port;
    way_t       fill_way;
    line_t      fill_line;

    modport lookup (
        output miss, addr_1, addr_2,
        input  fill_valid, fill_port, fill_way, fill_line
    );

    modport refill (
        input  miss, addr_1, addr_2,
        output fill_valid, fill_port, fill_way, fill_line
    );

endinterface

/* src/icache_dp_bram.sv */
`timescale 1ns/1ns

module icache_dp_bram
    import icache_pkg::*;
#(
    parameter int WIDTH = LINE_W
) (
    input  logic             clk_i,

    input  logic             we_a_i,
    input  index_t           addr_a_i,
    input  logic [WIDTH-1:0] din_a_i,
    output logic [WIDTH-1:0] dout_a_o,

    input  logic             we_b_i,
    input  index_t           addr_b_i,
    input  logic [WIDTH-1:0] din_b_i,
    output logic [WIDTH-1:0] dout_b_o
);

    logic [WIDTH-1:0] mem [NSET];

    // Read-first on both ports, old contents come out on a write
    always_ff @(posedge clk_i) begin
        if (we_a_i) begin
            mem[addr_a_i] <= din_a_i;
        end
        if (we_b_i) begin
            mem[addr_b_i] <= din_b_i;
        end
        dout_a_o <= mem[addr_a_i];
        dout_b_o <= mem[addr_b_i];
    end

endmodule

/* src/icache_lookup.sv */
`timescale 1ns/1ns

module icache_lookup
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       rreq_1_i,
    input  addr_t                      raddr_1_i,
    input  logic                       rreq_2_i,
    input  addr_t                      raddr_2_i,

    // RAM side, [way][ram port]
    input  tag_t  [NWAY-1:0][1:0]      tag_rdata_i,
    input  line_t [NWAY-1:0][1:0]      data_rdata_i,
    output logic  [NWAY-1:0][1:0]      tag_we_o,
    output logic  [NWAY-1:0][1:0]      data_we_o,
    output tag_t  [1:0]                tag_wdata_o,
    output line_t [1:0]                data_wdata_o,
    output index_t [1:0]               ram_addr_o,

    output logic                       rvalid_1_o,
    output line_t                      rdata_1_o,
    output logic                       rvalid_2_o,
    output line_t                      rdata_2_o,

    icache_fill_if.lookup              fill
);

    function automatic index_t idx_of(input addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t tag_of(input addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    logic  [1:0]                rreq;
    addr_t [1:0]                raddr;
    logic  [1:0]                req_q;
    addr_t [1:0]                addr_q;
    logic  [1:0][NWAY-1:0]      valid_q;
    logic  [NWAY-1:0][NSET-1:0] valid_r;
    logic                       fill_q;
    addr_t                      fill_addr;
    logic  [1:0]                hit;
    logic  [1:0]                fill_same;
    line_t [1:0]                rdata;

    assign rreq  = {rreq_2_i, rreq_1_i};
    assign raddr = {raddr_2_i, raddr_1_i};
    assign fill_addr = addr_q[fill.fill_port];

    ////////////////////////////////////////////////////////////
    // RAM addressing and refill writes
    ////////////////////////////////////////////////////////////

    always_comb begin
        tag_we_o  = '0;
        data_we_o = '0;
        for (int p = 0; p < 2; p++) begin
            ram_addr_o[p]   = idx_of(raddr[p]);
            tag_wdata_o[p]  = tag_of(addr_q[p]);
            data_wdata_o[p] = fill.fill_line;
        end
        if (fill.fill_valid) begin
            tag_we_o[fill.fill_way][fill.fill_port]  = 1'b1;
            data_we_o[fill.fill_way][fill.fill_port] = 1'b1;
            ram_addr_o[fill.fill_port] = idx_of(fill_addr);
        end
    end

    // Valid bits are sampled with the RAM read so both snapshots agree
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q   <= '0;
            valid_q <= '0;
            valid_r <= '0;
            fill_q  <= 1'b0;
        end else begin
            req_q  <= rreq;
            fill_q <= fill.fill_valid;
            for (int p = 0; p < 2; p++) begin
                for (int w = 0; w < NWAY; w++) begin
                    valid_q[p][w] <= valid_r[w][ram_addr_o[p]];
                end
            end
            if (fill.fill_valid) begin
                valid_r[fill.fill_way][idx_of(fill_addr)] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= raddr;
    end

    ////////////////////////////////////////////////////////////
    // Hit compare and way select
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            hit[p]   = 1'b0;
            rdata[p] = '0;
            for (int w = 0; w < NWAY; w++) begin
                if (valid_q[p][w] && tag_rdata_i[w][p] == tag_of(addr_q[p])) begin
                    hit[p]   = 1'b1;
                    rdata[p] = data_rdata_i[w][p];
                end
            end
            // Line being written now will hit on its own
            fill_same[p] = fill.fill_valid &&
                addr_q[p][ADDR_W-1:OFFSET_W] == fill_addr[ADDR_W-1:OFFSET_W];
            // Snapshot taken on a fill edge is stale for one cycle
            fill.miss[p] = req_q[p] & ~hit[p] & ~fill_q & ~fill_same[p];
        end
    end

    assign rvalid_1_o  = req_q[0] & hit[0];
    assign rvalid_2_o  = req_q[1] & hit[1];
    assign rdata_1_o   = rdata[0];
    assign rdata_2_o   = rdata[1];
    assign fill.addr_1 = addr_q[0];
    assign fill.addr_2 = addr_q[1];

endmodule

/* src/icache_refill.sv */
`timescale 1ns/1ns

module icache_refill
    import icache_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    icache_fill_if.refill fill,

    // Memory controller
    output logic          mem_rreq_o,
    output addr_t         mem_addr_o,
    input  logic          mem_rdy_i,
    input  logic          mem_rvalid_i,
    input  line_t         mem_data_i
);

    refill_state_e state_q;
    refill_state_e state_d;
    way_t          victim_q;
    logic          port_sel;
    addr_t         port_addr;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fill.miss[0]) begin
                    state_d = REQ_1;
                end else if (fill.miss[1]) begin
                    state_d = REQ_2;
                end
            end
            REQ_1: begin
                if (mem_rdy_i) begin
                    state_d = WAIT_1;
                end
            end
            WAIT_1: begin
                if (mem_rvalid_i) begin
                    state_d = fill.miss[1] ? REQ_2 : IDLE;
                end
            end
            REQ_2: begin
                if (mem_rdy_i) begin
                    state_d = WAIT_2;
                end
            end
            WAIT_2: begin
                if (mem_rvalid_i) begin
                    state_d = fill.miss[0] ? REQ_1 : IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Memory request and fill strobe
    ////////////////////////////////////////////////////////////

    assign port_sel  = (state_q == REQ_2) || (state_q == WAIT_2);
    assign port_addr = port_sel ? fill.addr_2 : fill.addr_1;

    // Request held through REQ and WAIT
    assign mem_rreq_o = (state_q != IDLE);
    assign mem_addr_o = mem_rreq_o ?
        {port_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} : '0;

    assign fill.fill_valid = mem_rvalid_i && (state_q == WAIT_1 || state_q == WAIT_2);
    assign fill.fill_port  = port_sel;
    assign fill.fill_way   = victim_q;
    assign fill.fill_line  = mem_data_i;

    // Round-robin victim, one step per fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= '0;
        end else if (fill.fill_valid) begin
            if (victim_q == way_t'(NWAY - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Read port 1
    input  logic  rreq_1_i,
    input  addr_t raddr_1_i,
    output logic  rvalid_1_o,
    output line_t rdata_1_o,

    // Read port 2
    input  logic  rreq_2_i,
    input  addr_t raddr_2_i,
    output logic  rvalid_2_o,
    output line_t rdata_2_o,

    // Memory controller
    output logic  mem_rreq_o,
    output addr_t mem_addr_o,
    input  logic  mem_rdy_i,
    input  logic  mem_rvalid_i,
    input  line_t mem_data_i
);

    tag_t   [NWAY-1:0][1:0] tag_rdata;
    line_t  [NWAY-1:0][1:0] data_rdata;
    logic   [NWAY-1:0][1:0] tag_we;
    logic   [NWAY-1:0][1:0] data_we;
    tag_t   [1:0]           tag_wdata;
    line_t  [1:0]           data_wdata;
    index_t [1:0]           ram_addr;

    icache_fill_if fill_if ();

    icache_lookup i_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .rreq_1_i     (rreq_1_i),
        .raddr_1_i    (raddr_1_i),
        .rreq_2_i     (rreq_2_i),
        .raddr_2_i    (raddr_2_i),
        .tag_rdata_i  (tag_rdata),
        .data_rdata_i (data_rdata),
        .tag_we_o     (tag_we),
        .data_we_o    (data_we),
        .tag_wdata_o  (tag_wdata),
        .data_wdata_o (data_wdata),
        .ram_addr_o   (ram_addr),
        .rvalid_1_o   (rvalid_1_o),
        .rdata_1_o    (rdata_1_o),
        .rvalid_2_o   (rvalid_2_o),
        .rdata_2_o    (rdata_2_o),
        .fill         (fill_if.lookup)
    );

    icache_refill i_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill         (fill_if.refill),
        .mem_rreq_o   (mem_rreq_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdy_i    (mem_rdy_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_data_i   (mem_data_i)
    );

    ////////////////////////////////////////////////////////////
    // Tag and data RAMs, RAM port A serves read port 1
    ////////////////////////////////////////////////////////////

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_dp_bram #(.WIDTH(TAG_W)) i_tag_ram (
            .clk_i    (clk),
            .we_a_i   (tag_we[w][0]),
            .addr_a_i (ram_addr[0]),
            .din_a_i  (tag_wdata[0]),
            .dout_a_o (tag_rdata[w][0]),
            .we_b_i   (tag_we[w][1]),
            .addr_b_i (ram_addr[1]),
            .din_b_i  (tag_wdata[1]),
            .dout_b_o (tag_rdata[w][1])
        );

        icache_dp_bram #(.WIDTH(LINE_W)) i_data_ram (
            .clk_i    (clk),
            .we_a_i   (data_we[w][0]),
            .addr_a_i (ram_addr[0]),
            .din_a_i  (data_wdata[0]),
            .dout_a_o (data_rdata[w][0]),
            .we_b_i   (data_we[w][1]),
            .addr_b_i (ram_addr[1]),
            .din_b_i  (data_wdata[1]),
            .dout_b_o (data_rdata[w][1])
        );
    end

endmodule

/* bench/icache_mem_model.sv */
`timescale 1ns/1ns

module icache_mem_model
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_rreq_i,
    input  addr_t mem_addr_i,
    output logic  mem_rdy_o,
    output logic  mem_rvalid_o,
    output line_t mem_data_o
);

    localparam logic [31:0] SEED = 32'hb87e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,
        M_WAIT
    } mem_phase_e;

    mem_phase_e  phase;
    logic [31:0] rnd;
    int          delay;
    addr_t       line_addr;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Each word holds its own byte address
    function automatic line_t line_data(input addr_t a);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = a + 32'(4 * i);
        end
        return l;
    endfunction

    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        = M_IDLE;
            rnd          = SEED;
            delay        = 0;
            line_addr    = '0;
            mem_rdy_o    <= 1'b0;
            mem_rvalid_o <= 1'b0;
            mem_data_o   <= '0;
        end else begin
            mem_rdy_o    <= 1'b0;
            mem_rvalid_o <= 1'b0;
            if (phase == M_IDLE && mem_rreq_i) begin
                // 0 to 3 cycles until ready
                rnd   = lcg_next(rnd);
                delay = int'(rnd[31:30]);
                phase = M_REQ;
            end
            if (phase == M_REQ) begin
                if (delay == 0) begin
                    mem_rdy_o <= 1'b1;
                    line_addr = mem_addr_i;
                    // Data 1 to 4 cycles after ready
                    rnd       = lcg_next(rnd);
                    delay     = int'(rnd[31:30]) + 1;
                    phase     = M_WAIT;
                end else begin
                    delay--;
                end
            end else if (phase == M_WAIT) begin
                delay--;
                if (delay == 0) begin
                    mem_rvalid_o <= 1'b1;
                    mem_data_o   <= line_data(line_addr);
                    phase        = M_IDLE;
                end
            end
        end
    end

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb
    import icache_pkg::*;
();

    localparam int    CLK_PERIOD      = 20;
    localparam int    RST_CYCLES      = 5;
    localparam int    MAX_TESTS       = 64;
    localparam int    CYCLES_PER_TEST = 40;
    localparam int    DRAIN_CYCLES    = 10;
    localparam string STIM_FILE       = "bench/icache_stimulus.txt";

    logic  clk;
    logic  rst_n;
    logic  rreq_1;
    addr_t raddr_1;
    logic  rvalid_1;
    line_t rdata_1;
    logic  rreq_2;
    addr_t raddr_2;
    logic  rvalid_2;
    line_t rdata_2;
    logic  mem_rreq;
    addr_t mem_addr;
    logic  mem_rdy;
    logic  mem_rvalid;
    line_t mem_data;

    logic  stim_en_1   [MAX_TESTS];
    addr_t stim_addr_1 [MAX_TESTS];
    logic  stim_en_2   [MAX_TESTS];
    addr_t stim_addr_2 [MAX_TESTS];
    logic  stim_miss_1 [MAX_TESTS];
    logic  stim_miss_2 [MAX_TESTS];
    int    n_tests;
    bit    loaded;

    // Reference model of tags, valid bits and victim pointer
    tag_t  model_tag   [NWAY][NSET];
    logic  model_valid [NWAY][NSET];
    int    model_ptr;
    int    model_fills;

    addr_t mem_seen_q [$];
    int    mem_req_total;
    int    n_checks;
    int    n_errors;

    icache_top i_icache_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .rreq_1_i     (rreq_1),
        .raddr_1_i    (raddr_1),
        .rvalid_1_o   (rvalid_1),
        .rdata_1_o    (rdata_1),
        .rreq_2_i     (rreq_2),
        .raddr_2_i    (raddr_2),
        .rvalid_2_o   (rvalid_2),
        .rdata_2_o    (rdata_2),
        .mem_rreq_o   (mem_rreq),
        .mem_addr_o   (mem_addr),
        .mem_rdy_i    (mem_rdy),
        .mem_rvalid_i (mem_rvalid),
        .mem_data_i   (mem_data)
    );

    icache_mem_model i_mem_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_rreq_i   (mem_rreq),
        .mem_addr_i   (mem_addr),
        .mem_rdy_o    (mem_rdy),
        .mem_rvalid_o (mem_rvalid),
        .mem_data_o   (mem_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One memory request accepted per ready
    always @(posedge clk) begin
        if (rst_n && mem_rreq && mem_rdy) begin
            mem_seen_q.push_back(mem_addr);
            mem_req_total++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address rules and cache model
    ////////////////////////////////////////////////////////////

    function automatic addr_t line_base(input addr_t a);
        return {a[31:4], 4'h0};
    endfunction

    function automatic line_t expect_line(input addr_t a);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = line_base(a) + 32'(4 * i);
        end
        return l;
    endfunction

    function automatic bit model_hit(input addr_t a);
        bit hit;
        hit = 1'b0;
        for (int w = 0; w < NWAY; w++) begin
            if (model_valid[w][a[11:4]] && model_tag[w][a[11:4]] == a[31:12]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic void model_fill(input addr_t a);
        model_tag[model_ptr][a[11:4]]   = a[31:12];
        model_valid[model_ptr][a[11:4]] = 1'b1;
        model_ptr = (model_ptr + 1) % NWAY;
        model_fills++;
    endfunction

    function automatic string port_status(input logic en, input logic miss);
        if (!en) begin
            return "idle";
        end
        return miss ? "miss" : "hit ";
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_line(input line_t got, input line_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus, reset and one test per stimulus line
    ////////////////////////////////////////////////////////////

    task automatic load_stimulus();
        int                fd;
        int                code;
        logic [31:0]       f [6];
        logic [8*160-1:0]  skip_line;
        n_tests = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fscanf(fd, " %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                if (code == 6) begin
                    stim_en_1[n_tests]   = f[0][0];
                    stim_addr_1[n_tests] = f[1];
                    stim_en_2[n_tests]   = f[2][0];
                    stim_addr_2[n_tests] = f[3];
                    stim_miss_1[n_tests] = f[4][0];
                    stim_miss_2[n_tests] = f[5][0];
                    n_tests++;
                end else begin
                    code = $fgets(skip_line, fd);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic apply_reset();
        #1;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_test(input int t);
        addr_t a1;
        addr_t a2;
        bit    miss_1;
        bit    miss_2;
        bit    pend_1;
        bit    pend_2;
        int    err_start;
        addr_t exp_q [$];
        a1 = stim_addr_1[t];
        a2 = stim_addr_2[t];
        err_start = n_errors;
        // Both lookups see the cache before this test's fills
        miss_1 = stim_en_1[t] && !model_hit(a1);
        miss_2 = stim_en_2[t] && !model_hit(a2);
        // A shared missing line is fetched once for port 1
        if (miss_1 && miss_2 && line_base(a1) == line_base(a2)) begin
            miss_2 = 1'b0;
        end
        if (miss_1 != stim_miss_1[t] || miss_2 != stim_miss_2[t]) begin
            n_errors++;
            $display("Stimulus line %0d expects misses %0d %0d but the model predicts %0d %0d",
                t + 1, stim_miss_1[t], stim_miss_2[t], miss_1, miss_2);
        end
        if (miss_1) begin
            model_fill(a1);
        end
        if (miss_2) begin
            model_fill(a2);
        end
        if (stim_miss_1[t]) begin
            exp_q.push_back(line_base(a1));
        end
        if (stim_miss_2[t]) begin
            exp_q.push_back(line_base(a2));
        end

        @(negedge clk);
        rreq_1  = stim_en_1[t];
        raddr_1 = a1;
        rreq_2  = stim_en_2[t];
        raddr_2 = a2;
        pend_1  = stim_en_1[t];
        pend_2  = stim_en_2[t];
        // Hold each request until its port answers
        while (pend_1 || pend_2) begin
            @(negedge clk);
            if (pend_1 && rvalid_1) begin
                check_line(rdata_1, expect_line(a1), $sformatf("test %0d port 1 line", t + 1));
                rreq_1 = 1'b0;
                pend_1 = 1'b0;
            end
            if (pend_2 && rvalid_2) begin
                check_line(rdata_2, expect_line(a2), $sformatf("test %0d port 2 line", t + 1));
                rreq_2 = 1'b0;
                pend_2 = 1'b0;
            end
        end

        check_count(mem_seen_q.size(), exp_q.size(), $sformatf("test %0d refills", t + 1));
        for (int i = 0; i < exp_q.size() && i < mem_seen_q.size(); i++) begin
            check_addr(mem_seen_q[i], exp_q[i], $sformatf("test %0d memory address %0d", t + 1, i));
        end
        $display("test %2d: port 1 %s %h, port 2 %s %h, %0d refills, %s",
            t + 1, port_status(stim_en_1[t], stim_miss_1[t]), a1,
            port_status(stim_en_2[t], stim_miss_2[t]), a2, mem_seen_q.size(),
            (n_errors == err_start) ? "ok" : $sformatf("%0d errors", n_errors - err_start));
        mem_seen_q.delete();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b1;
        rreq_1        = 1'b0;
        raddr_1       = '0;
        rreq_2        = 1'b0;
        raddr_2       = '0;
        loaded        = 1'b0;
        model_ptr     = 0;
        model_fills   = 0;
        mem_req_total = 0;
        n_checks      = 0;
        n_errors      = 0;
        for (int w = 0; w < NWAY; w++) begin
            for (int s = 0; s < NSET; s++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s]   = '0;
            end
        end
        load_stimulus();
        if (n_tests == 0) begin
            $display("No stimulus lines could be read from %s", STIM_FILE);
            $display("CHECKS FAILED");
            $finish;
        end else begin
            apply_reset();
            for (int t = 0; t < n_tests; t++) begin
                run_test(t);
            end
            // Idle cycles so a late memory request still reaches the total
            repeat (DRAIN_CYCLES) @(negedge clk);
            check_count(mem_req_total, model_fills, "total refills");
            $display("%0d tests, %0d checks, %0d errors, %0d refills",
                n_tests, n_checks, n_errors, mem_req_total);
            if (n_errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // Watchdog budget grows with the number of stimulus lines
    initial begin
        refill_state_e st;
        wait (loaded);
        #((RST_CYCLES + 4 + DRAIN_CYCLES + n_tests * CYCLES_PER_TEST) * CLK_PERIOD);
        st = i_icache_top.i_refill.state_q;
        $display("Run timed out at %0t ns with the refill FSM in %s, a request never returned",
            $time, st.name());
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* icache.f */
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_dp_bram.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

/* bench/icache_stimulus.txt */
# en1 addr1 en2 addr2 miss1 miss2, all hex, one request pair per line
# miss flags mark the ports that must trigger a memory request
# cold misses after reset
1 00001000 0 00000000 1 0
0 00000000 1 00002014 0 1
1 0000302c 1 00004038 1 1
# repeat hits
1 00001004 0 00000000 0 0
1 00002010 1 0000100c 0 0
1 00003020 1 00004030 0 0
# two ways in set 10
1 00010100 0 00000000 1 0
0 00000000 1 00020104 0 1
1 00020108 1 0001010c 0 0
1 00010100 1 00020100 0 0
1 00020100 0 00000000 0 0
# conflict eviction in set 10
1 00030100 0 00000000 1 0
1 00020100 0 00000000 0 0
1 00030104 0 00000000 0 0
1 00010100 0 00000000 1 0
1 00030100 1 00010100 0 0
0 00000000 1 00020100 0 1
1 00020100 1 00010100 0 0
# dual-port hits, same line on both ports too
1 00001000 1 00001008 0 0
1 00004030 1 00004030 0 0
1 00002010 1 00003020 0 0
# simultaneous misses
1 00050200 1 00060300 1 1
1 00070400 1 00080400 1 1
1 00070404 1 00080408 0 0
1 00090500 1 00090504 1 0
1 00050200 1 00090500 0 0
1 000a0400 1 000b0400 1 1
1 00070400 0 00000000 1 0
1 000b0400 1 00070400 0 0
1 00060300 1 00050200 0 0
